//--- rtl/rob_config_pkg.sv
/*
 * ROB back end sizing
 * Entry count, tag and counter widths, register and data widths
 */
package rob_config_pkg;

    ////////////////////////////////////////////////////////////
    // ROB geometry
    ////////////////////////////////////////////////////////////
    localparam int ROB_SZ    = 8;                 // Number of ROB slots
    localparam int ROB_TAG_W = $clog2(ROB_SZ);    // Tag is the slot index
    localparam int ROB_CNT_W = ROB_TAG_W + 1;     // Must reach ROB_SZ itself

    // Architectural widths
    localparam int REG_W  = 5;                    // 32 architectural registers
    localparam int DATA_W = 32;
    localparam int IMM_W  = 16;

endpackage

//--- rtl/rob_types_pkg.sv
/*
 * ROB back end data types
 * Instruction word with its two decodes, dispatch packet, ROB entry
 */
package rob_types_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction word, form bit in the MSB for both layouts
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                               form;   // 0 for reg-reg
        logic [rob_config_pkg::REG_W-1:0]   rd;
        logic [rob_config_pkg::REG_W-1:0]   rs1;
        logic [rob_config_pkg::REG_W-1:0]   rs2;
        logic [rob_config_pkg::DATA_W-1-3*rob_config_pkg::REG_W-1:0] spare;
    } instr_rr_t;

    typedef struct packed {
        logic                               form;   // 1 for reg-imm
        logic [rob_config_pkg::REG_W-1:0]   rd;
        logic [rob_config_pkg::REG_W-1:0]   rs1;
        logic [rob_config_pkg::REG_W-1:0]   spare;
        logic [rob_config_pkg::IMM_W-1:0]   imm;    // Two's complement
    } instr_ri_t;

    // Same 32 bits, two readings
    typedef union packed {
        instr_rr_t rr;
        instr_ri_t ri;
    } instr_word_u;

    ////////////////////////////////////////////////////////////
    // Decoded packet and ROB slot
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                               is_imm;
        logic [rob_config_pkg::REG_W-1:0]   rd;
        logic [rob_config_pkg::REG_W-1:0]   rs1;
        logic [rob_config_pkg::REG_W-1:0]   rs2;    // Zero for reg-imm
        logic [rob_config_pkg::IMM_W-1:0]   imm;    // Zero for reg-reg
    } dispatch_pkt_t;

    typedef struct packed {
        logic                                valid;
        logic                                complete;  // Result written back
        logic [rob_config_pkg::ROB_TAG_W-1:0] tag;
        dispatch_pkt_t                       pkt;
        logic [rob_config_pkg::DATA_W-1:0]   value;
    } rob_entry_t;

endpackage

//--- rtl/dispatch_stage.sv
/*
 * Dispatch stage
 * Four-phase input handshake, form decode, ROB allocation request
 */
module dispatch_stage (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         in_req,
    input  rob_types_pkg::instr_word_u   in_word,
    output logic                         in_ack,
    input  logic                         alloc_ready,   // ROB not full
    output logic                         alloc_valid,
    output rob_types_pkg::dispatch_pkt_t alloc_pkt
);

    typedef enum logic [1:0] {
        S_IDLE,      // Waiting for in_req
        S_ALLOC,     // Holding alloc_valid until accepted
        S_ACKED,     // in_ack high, waiting for in_req low
        S_RELEASE    // in_ack dropped, one cycle before idle
    } disp_state_e;

    disp_state_e                 state;
    rob_types_pkg::instr_word_u  word_q;    // Captured instruction

    ////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:    if (in_req) state <= S_ALLOC;
                S_ALLOC:   if (alloc_ready) state <= S_ACKED;  // Allocation this cycle
                S_ACKED:   if (!in_req) state <= S_RELEASE;
                S_RELEASE: state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // Word is stable while in_req is high
    always_ff @(posedge clock) begin
        if (state == S_IDLE && in_req) begin
            word_q <= in_word;
        end
    end

    assign alloc_valid = (state == S_ALLOC);
    assign in_ack      = (state == S_ACKED);

    ////////////////////////////////////////////////////////////
    // Form decode through the union
    ////////////////////////////////////////////////////////////
    always_comb begin
        alloc_pkt.is_imm = word_q.ri.form;
        alloc_pkt.rd     = word_q.rr.rd;     // Same spot in both forms
        alloc_pkt.rs1    = word_q.rr.rs1;
        if (word_q.ri.form) begin
            alloc_pkt.rs2 = '0;
            alloc_pkt.imm = word_q.ri.imm;
        end else begin
            alloc_pkt.rs2 = word_q.rr.rs2;
            alloc_pkt.imm = '0;              // No immediate in reg-reg
        end
    end

endmodule

//--- rtl/reorder_buffer.sv
/*
 * Reorder buffer
 * Circular slot array with tag = slot index, completion by tag,
 * in-order release from the head
 */
module reorder_buffer (
    input  logic                                   clock,
    input  logic                                   reset,
    // Allocation from dispatch
    input  logic                                   alloc_valid,
    input  rob_types_pkg::dispatch_pkt_t           alloc_pkt,
    output logic                                   alloc_ready,
    // Issue announcement
    output logic                                   issue_valid,
    output logic [rob_config_pkg::ROB_TAG_W-1:0]   issue_tag,
    output rob_types_pkg::dispatch_pkt_t           issue_pkt,
    // Completion bus
    input  logic                                   cdb_valid,
    input  logic [rob_config_pkg::ROB_TAG_W-1:0]   cdb_tag,
    input  logic [rob_config_pkg::DATA_W-1:0]      cdb_value,
    // Head to retire
    input  logic                                   head_take,
    output logic                                   head_valid,
    output rob_types_pkg::rob_entry_t              head_entry
);

    ////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////
    logic [rob_config_pkg::ROB_SZ-1:0]     valid_q;     // Slot holds an instruction
    logic [rob_config_pkg::ROB_SZ-1:0]     complete_q;  // Slot has its result

    rob_types_pkg::dispatch_pkt_t          pkt_mem   [rob_config_pkg::ROB_SZ];
    logic [rob_config_pkg::DATA_W-1:0]     value_mem [rob_config_pkg::ROB_SZ];

    logic [rob_config_pkg::ROB_TAG_W-1:0]  head;
    logic [rob_config_pkg::ROB_TAG_W-1:0]  tail;
    logic [rob_config_pkg::ROB_CNT_W-1:0]  count;       // Occupied slots

    logic alloc_fire;
    logic release_fire;
    logic cdb_hit;

    assign alloc_ready  = (count < rob_config_pkg::ROB_SZ);
    assign alloc_fire   = alloc_valid && alloc_ready;
    assign release_fire = head_valid && head_take;
    assign cdb_hit      = cdb_valid && valid_q[cdb_tag];  // Empty slot ignored

    // Issue port follows the allocation combinationally
    assign issue_valid = alloc_fire;
    assign issue_tag   = tail;
    assign issue_pkt   = alloc_pkt;

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q    <= '0;
            complete_q <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
        end else begin
            if (cdb_hit) complete_q[cdb_tag] <= 1'b1;

            if (release_fire) begin
                valid_q[head]    <= 1'b0;   // Free the head slot
                complete_q[head] <= 1'b0;
                head             <= head + 1'b1;
            end

            // Never the head slot while release can fire
            if (alloc_fire) begin
                valid_q[tail]    <= 1'b1;
                tail             <= tail + 1'b1;  // Wraps at ROB_SZ
            end

            case ({alloc_fire, release_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Both or neither
            endcase
        end
    end

    // Payload, no reset needed
    always_ff @(posedge clock) begin
        if (alloc_fire) pkt_mem[tail] <= alloc_pkt;
        if (cdb_hit) value_mem[cdb_tag] <= cdb_value;
    end

    ////////////////////////////////////////////////////////////
    // Head view
    ////////////////////////////////////////////////////////////
    assign head_valid = valid_q[head] && complete_q[head];

    always_comb begin
        head_entry.valid    = valid_q[head];
        head_entry.complete = complete_q[head];
        head_entry.tag      = head;              // Tag equals slot index
        head_entry.pkt      = pkt_mem[head];
        head_entry.value    = value_mem[head];
    end

endmodule

//--- rtl/retire_stage.sv
/*
 * Retire stage
 * Holds one released ROB entry, four-phase output handshake
 */
module retire_stage (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  head_valid,
    input  rob_types_pkg::rob_entry_t             head_entry,
    output logic                                  head_take,
    output logic                                  out_req,
    input  logic                                  out_ack,
    output logic [rob_config_pkg::REG_W-1:0]      out_rd,
    output logic [rob_config_pkg::DATA_W-1:0]     out_value,
    output logic [rob_config_pkg::ROB_TAG_W-1:0]  out_tag
);

    typedef enum logic [1:0] {
        S_IDLE,      // Ready to take the head
        S_REQ,       // out_req high until out_ack seen
        S_RELEASE    // Waiting for out_ack low
    } ret_state_e;

    ret_state_e                 state;
    rob_types_pkg::rob_entry_t  held_q;    // Entry being retired

    assign head_take = (state == S_IDLE);

    ////////////////////////////////////////////////////////////
    // Output handshake FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:    if (head_valid) state <= S_REQ;  // Release this cycle
                S_REQ:     if (out_ack) state <= S_RELEASE;
                S_RELEASE: if (!out_ack) state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // Capture on release, stable through the exchange
    always_ff @(posedge clock) begin
        if (state == S_IDLE && head_valid) begin
            held_q <= head_entry;
        end
    end

    assign out_req   = (state == S_REQ);
    assign out_rd    = held_q.pkt.rd;
    assign out_value = held_q.value;
    assign out_tag   = held_q.tag;

endmodule

//--- rtl/rob_backend_top.sv
/*
 * ROB back end top level
 * Dispatch, reorder buffer and retire connected in a chain
 */
module rob_backend_top (
    input  logic                                  clock,
    input  logic                                  reset,
    // Instruction input, four-phase
    input  logic                                  in_req,
    input  rob_types_pkg::instr_word_u            in_word,
    output logic                                  in_ack,
    // Issue announcement
    output logic                                  issue_valid,
    output logic [rob_config_pkg::ROB_TAG_W-1:0]  issue_tag,
    output rob_types_pkg::dispatch_pkt_t          issue_pkt,
    // Completion bus
    input  logic                                  cdb_valid,
    input  logic [rob_config_pkg::ROB_TAG_W-1:0]  cdb_tag,
    input  logic [rob_config_pkg::DATA_W-1:0]     cdb_value,
    // Retire output, four-phase
    output logic                                  out_req,
    input  logic                                  out_ack,
    output logic [rob_config_pkg::REG_W-1:0]      out_rd,
    output logic [rob_config_pkg::DATA_W-1:0]     out_value,
    output logic [rob_config_pkg::ROB_TAG_W-1:0]  out_tag
);

    ////////////////////////////////////////////////////////////
    // Inter-stage wires
    ////////////////////////////////////////////////////////////
    logic                          alloc_valid;
    logic                          alloc_ready;
    rob_types_pkg::dispatch_pkt_t  alloc_pkt;
    logic                          head_valid;
    logic                          head_take;
    rob_types_pkg::rob_entry_t     head_entry;

    dispatch_stage i_dispatch_stage (
        .clock, .reset, .in_req, .in_word, .in_ack,
        .alloc_ready, .alloc_valid, .alloc_pkt
    );

    reorder_buffer i_reorder_buffer (
        .clock, .reset, .alloc_valid, .alloc_pkt, .alloc_ready,
        .issue_valid, .issue_tag, .issue_pkt,
        .cdb_valid, .cdb_tag, .cdb_value,
        .head_take, .head_valid, .head_entry
    );

    retire_stage i_retire_stage (
        .clock, .reset, .head_valid, .head_entry, .head_take,
        .out_req, .out_ack, .out_rd, .out_value, .out_tag
    );

endmodule

//--- dv/rob_backend_tb.sv
/*
 * ROB back end testbench
 * Table-driven dispatch, out-of-order completion model, in-order retire checks
 */
module rob_backend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_ROWS    = 12;
    localparam int WATCHDOG_NS = NUM_ROWS * 200 * CLK_PERIOD;  // 200 cycles per row

    logic                                  clock = 1'b0;
    logic                                  reset;
    logic                                  in_req;
    rob_types_pkg::instr_word_u            in_word;
    logic                                  in_ack;
    logic                                  issue_valid;
    logic [rob_config_pkg::ROB_TAG_W-1:0]  issue_tag;
    rob_types_pkg::dispatch_pkt_t          issue_pkt;
    logic                                  cdb_valid = 1'b0;
    logic [rob_config_pkg::ROB_TAG_W-1:0]  cdb_tag   = '0;
    logic [rob_config_pkg::DATA_W-1:0]     cdb_value = '0;
    logic                                  out_req;
    logic                                  out_ack;
    logic [rob_config_pkg::REG_W-1:0]      out_rd;
    logic [rob_config_pkg::DATA_W-1:0]     out_value;
    logic [rob_config_pkg::ROB_TAG_W-1:0]  out_tag;

    ////////////////////////////////////////////////////////////
    // Stimulus table and scoreboard state
    ////////////////////////////////////////////////////////////
    string       row_name  [NUM_ROWS];
    logic [31:0] row_word  [NUM_ROWS];
    int          row_delay [NUM_ROWS];   // Completion delay, cycles
    int          row_hold  [NUM_ROWS];   // out_ack hold-off, cycles
    logic [31:0] row_rd    [NUM_ROWS];
    logic [31:0] row_value [NUM_ROWS];   // Expected result

    logic [31:0] ref_tag[$];             // Reference queue, table order
    logic [31:0] ref_rd[$];
    logic [31:0] ref_value[$];
    int          pend_tag[$];            // Results waiting for the CDB
    logic [31:0] pend_value[$];
    int          pend_due[$];

    logic [7:0]  lfsr = 8'd70;
    int          cycle = 0;
    int          issued = 0;
    int          retire_starts = 0;      // out_req rising edges
    int          retired = 0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    int          next_tag = 0;
    int          pick;
    bit          issue_bad [NUM_ROWS];   // Issue check failed for this row
    logic        in_ack_d = 1'b0;
    logic        out_req_d = 1'b0;
    logic [rob_config_pkg::ROB_TAG_W-1:0] held_tag;
    logic [rob_config_pkg::REG_W-1:0]     held_rd;
    logic [rob_config_pkg::DATA_W-1:0]    held_value;

    rob_backend_top i_rob_backend_top (
        .clock, .reset, .in_req, .in_word, .in_ack,
        .issue_valid, .issue_tag, .issue_pkt,
        .cdb_valid, .cdb_tag, .cdb_value,
        .out_req, .out_ack, .out_rd, .out_value, .out_tag
    );

    always #(CLK_PERIOD / 2) clock = ~clock;
    always @(posedge clock) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] rr_word(input int rd, rs1, rs2, spare);
        return {1'b0, 5'(rd), 5'(rs1), 5'(rs2), 16'(spare)};
    endfunction

    function automatic logic [31:0] ri_word(input int rd, rs1, spare, imm);
        return {1'b1, 5'(rd), 5'(rs1), 5'(spare), 16'(imm)};
    endfunction

    // Fibonacci LFSR x^8+x^6+x^5+x^4+1, one step per bit
    function automatic int lfsr_take(input int nbits);
        int   val;
        logic fb;
        val = 0;
        for (int k = 0; k < nbits; k++) begin
            fb   = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
            lfsr = {lfsr[6:0], fb};
            val  = (val << 1) | fb;
        end
        return val;
    endfunction

    // Execution model, register index used as operand value
    function automatic logic [31:0] execute(input rob_types_pkg::dispatch_pkt_t pkt);
        logic [31:0] imm_ext;
        imm_ext = {{16{pkt.imm[15]}}, pkt.imm};
        if (pkt.is_imm) return 32'(pkt.rs1) + imm_ext;
        return 32'(pkt.rs1) + 32'(pkt.rs2);
    endfunction

    function automatic bit retire_data_moved();
        return (out_tag !== held_tag) || (out_rd !== held_rd) || (out_value !== held_value);
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act, inout bit bad);
        if (exp !== act) begin
            $display("Fail %s: %s expected %0h, actual %0h", test, field, exp, act);
            errors++;
            bad = 1'b1;
        end
    endtask

    task automatic set_row(input int idx, input string name, input logic [31:0] word,
                           input int delay, hold, rd, input logic [31:0] value);
        row_name[idx]  = name;
        row_word[idx]  = word;
        row_delay[idx] = delay;
        row_hold[idx]  = hold;
        row_rd[idx]    = rd;
        row_value[idx] = value;
    endtask

    task automatic load_table();
        // Row 0 completes late so the ROB fills behind it
        set_row(0,  "rr_long_wait", rr_word(1, 3, 4, 0),           80, 15, 1,  32'd7);
        set_row(1,  "ri_pos",       ri_word(2, 10, 0, 100),         3,  0, 2,  32'd110);
        set_row(2,  "ri_neg",       ri_word(3, 5, 0, -20),          1,  2, 3,  32'hffff_fff1);
        set_row(3,  "rr_max_regs",  rr_word(4, 31, 31, 0),          6,  1, 4,  32'd62);
        set_row(4,  "ri_min_imm",   ri_word(5, 0, 0, 'h8000),       2,  0, 5,  32'hffff_8000);
        set_row(5,  "rr_zero",      rr_word(6, 0, 0, 0),            9,  4, 6,  32'd0);  // Tag 5
        set_row(6,  "ri_max_imm",   ri_word(7, 1, 0, 'h7fff),       4,  0, 7,  32'h0000_8000);
        set_row(7,  "rr_spare_set", rr_word(8, 2, 9, 'habcd),       1,  2, 8,  32'd11);
        set_row(8,  "wrap_tag0",    ri_word(9, 7, 0, -7),           5,  6, 9,  32'd0);
        set_row(9,  "ri_spare_set", ri_word(10, 4, 'h1f, 1),        2,  0, 10, 32'd5);
        set_row(10, "rr_rd31",      rr_word(31, 17, 13, 0),         7,  3, 31, 32'd30);
        set_row(11, "ri_neg_big",   ri_word(0, 31, 0, -1000),       3,  1, 0,  32'hffff_fc37);
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor for issue events and the input handshake
    ////////////////////////////////////////////////////////////
    always @(negedge clock) begin
        if (!reset) begin
            if (out_req && !out_req_d) retire_starts++;
            if (in_ack && !in_ack_d && !in_req) begin
                $display("in_ack rose while in_req was low, cycle %0d", cycle);
                errors++;
            end
            if (issue_valid && issued >= NUM_ROWS) begin
                $display("Issue event with no dispatch pending, cycle %0d", cycle);
                errors++;
            end else if (issue_valid) begin
                check_value(row_name[issued], "issue_tag", next_tag, issue_tag,
                            issue_bad[issued]);
                if (issued == rob_config_pkg::ROB_SZ && retire_starts == 0) begin
                    $display("Ninth instruction issued while the ROB was full");
                    errors++;
                end
                pend_tag.push_back(issue_tag);
                pend_value.push_back(execute(issue_pkt));
                pend_due.push_back(cycle + row_delay[issued] + lfsr_take(3));  // Scramble
                next_tag = (next_tag + 1) % rob_config_pkg::ROB_SZ;
                issued++;
            end
            in_ack_d  = in_ack;
            out_req_d = out_req;
        end
    end

    // Completion bus, first due result each cycle
    always @(posedge clock) begin
        pick = -1;
        for (int j = 0; j < pend_due.size(); j++) begin
            if (pick < 0 && !reset && pend_due[j] <= cycle) pick = j;
        end
        if (pick >= 0) begin
            cdb_valid <= 1'b1;
            cdb_tag   <= pend_tag[pick];
            cdb_value <= pend_value[pick];
            pend_tag.delete(pick);
            pend_value.delete(pick);
            pend_due.delete(pick);
        end else begin
            cdb_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Retire side, checks against the reference queue
    ////////////////////////////////////////////////////////////
    initial begin
        string name;
        int    hold;
        bit    bad;
        out_ack = 1'b0;
        forever begin
            do @(negedge clock); while (!out_req);
            bad        = 1'b0;
            held_tag   = out_tag;
            held_rd    = out_rd;
            held_value = out_value;
            if (retired >= NUM_ROWS || ref_tag.size() == 0) begin
                $display("Retire of tag %0d with no instruction outstanding", out_tag);
                errors++;
                name = "extra_retire";
                hold = 0;
                bad  = 1'b1;
            end else begin
                name = row_name[retired];
                hold = row_hold[retired];
                bad  = issue_bad[retired];
                check_value(name, "out_tag", ref_tag.pop_front(), out_tag, bad);
                check_value(name, "out_rd", ref_rd.pop_front(), out_rd, bad);
                check_value(name, "out_value", ref_value.pop_front(), out_value, bad);
            end
            repeat (hold) begin                 // Hold-off, data must not move
                @(negedge clock);
                if (!out_req || retire_data_moved()) begin
                    $display("Retire data of %s changed before out_ack", name);
                    errors++;
                    bad = 1'b1;
                end
            end
            @(posedge clock);
            out_ack <= 1'b1;
            @(negedge clock);
            while (out_req) begin
                if (retire_data_moved()) begin
                    $display("Retire data of %s changed while out_req was high", name);
                    errors++;
                    bad = 1'b1;
                end
                @(negedge clock);
            end
            @(posedge clock);
            out_ack <= 1'b0;
            if (bad) begin
                failed++;
                $display("Test %-14s fail", name);
            end else begin
                passed++;
                $display("Test %-14s pass  tag %0d rd %0d value %h", name,
                         held_tag, held_rd, held_value);
            end
            retired++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int prev_tag;
        reset   = 1'b1;
        in_req  = 1'b0;
        in_word = '0;
        load_table();
        prev_tag = rob_config_pkg::ROB_SZ - 1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            prev_tag = (prev_tag + 1) % rob_config_pkg::ROB_SZ;
            ref_tag.push_back(prev_tag);
            ref_rd.push_back(row_rd[i]);
            ref_value.push_back(row_value[i]);
        end
        // Stray strobe to slot 0 before row 0 claims it and waits at the head
        pend_tag.push_back(0);
        pend_value.push_back(32'hdead_beef);
        pend_due.push_back(0);

        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (in_ack || out_req || issue_valid) begin
            $display("Outputs not idle after reset");
            errors++;
        end
        repeat (4) @(posedge clock);

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clock);
            in_req  <= 1'b1;
            in_word <= row_word[i];
            do @(negedge clock); while (!in_ack);
            @(posedge clock);
            in_req <= 1'b0;
            do @(negedge clock); while (in_ack);
        end
        while (retired < NUM_ROWS) @(negedge clock);
        repeat (20) @(negedge clock);           // Room for a spurious retire

        $display("Tests %0d  pass %0d  fail %0d  errors %0d", NUM_ROWS, passed, failed, errors);
        if (errors == 0 && passed == NUM_ROWS) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS + 10 * CLK_PERIOD);
        $display("Watchdog expired after %0d ns, the run hung", WATCHDOG_NS + 10 * CLK_PERIOD);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- project.f
rtl/rob_config_pkg.sv
rtl/rob_types_pkg.sv
rtl/dispatch_stage.sv
rtl/reorder_buffer.sv
rtl/retire_stage.sv
rtl/rob_backend_top.sv
dv/rob_backend_tb.sv
